/* bench/coreSliceChecks.svh */
`ifndef CORE_SLICE_CHECKS_SVH
`define CORE_SLICE_CHECKS_SVH

// Instruction encoders, one per RV32I format
function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP};
endfunction

function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input opcodeE opc);
    return {imm, rs1, f3, rd, opc};
endfunction

// Store offset split around rs2 and rs1
function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
endfunction

// Branch offset is even, bit 0 not encoded
function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
endfunction

function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                     input opcodeE opc);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
endfunction

// Write-back payload only compared while valid
task automatic checkWb(input string tag, input wbT expWb, input wbT actWb);
    if (actWb.valid !== expWb.valid)
    begin
        $display("ERR wb.valid exp %h act %h (%s)", expWb.valid, actWb.valid, tag);
        wbErrs++;
    end
    else if (expWb.valid && actWb.rd !== expWb.rd)
    begin
        $display("ERR wb.rd exp %h act %h (%s)", expWb.rd, actWb.rd, tag);
        wbErrs++;
    end
    else if (expWb.valid && actWb.data !== expWb.data)
    begin
        $display("ERR wb.data exp %08h act %08h (%s)", expWb.data, actWb.data, tag);
        wbErrs++;
    end
endtask

task automatic checkBranch(input string tag, input branchT expBr, input branchT actBr);
    if (actBr.taken !== expBr.taken)
    begin
        $display("ERR branch.taken exp %h act %h (%s)", expBr.taken, actBr.taken, tag);
        brErrs++;
    end
    else if (expBr.taken && actBr.target !== expBr.target)
    begin
        $display("ERR branch.target exp %08h act %08h (%s)", expBr.target, actBr.target,
                 tag);
        brErrs++;
    end
endtask

// Address checked on any strobe, wdata on stores only
task automatic checkMem(input string tag, input memReqT expReq, input memReqT actReq);
    if (actReq.read !== expReq.read || actReq.write !== expReq.write)
    begin
        $display("ERR memReq.read/write exp %h/%h act %h/%h (%s)", expReq.read,
                 expReq.write, actReq.read, actReq.write, tag);
        memErrs++;
    end
    else
    begin
        if ((expReq.read || expReq.write) && actReq.addr !== expReq.addr)
        begin
            $display("ERR memReq.addr exp %08h act %08h (%s)", expReq.addr, actReq.addr, tag);
            memErrs++;
        end
        if (expReq.write && actReq.wdata !== expReq.wdata)
        begin
            $display("ERR memReq.wdata exp %08h act %08h (%s)", expReq.wdata, actReq.wdata,
                     tag);
            memErrs++;
        end
    end
endtask

task automatic checkFlag(input string tag, input logic expBit, input logic actBit);
    if (actBit !== expBit)
    begin
        $display("ERR illegal exp %h act %h (%s)", expBit, actBit, tag);
        flagErrs++;
    end
endtask

`endif

/* bench/coreSliceTb.sv */
`timescale 1ns/1ps

module coreSliceTb;
    import rvPkg::*;

    localparam int CYCLE_LIMIT = 20000;

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic [31:0] instrPc;
    logic [31:0] loadData;
    memReqT      memReq;
    wbT          wb;
    branchT      branch;
    logic        illegal;

    logic [31:0] mem [256];
    logic [31:0] refRegs [32];
    logic [31:0] pc;
    int          seed;
    int          wbErrs = 0;
    int          brErrs = 0;
    int          memErrs = 0;
    int          flagErrs = 0;
    logic        finished = 1'b0;

    // Outputs captured at fixed latency after each issue
    memReqT      seenReq;
    wbT          seenWb;
    branchT      seenBr;
    logic        seenIll;

    `include "coreSliceChecks.svh"

    coreSlice dut0 (
        .clk      (clk),
        .rst      (rst),
        .instr    (instr),
        .instrPc  (instrPc),
        .loadData (loadData),
        .memReq   (memReq),
        .wb       (wb),
        .branch   (branch),
        .illegal  (illegal)
    );

    // Data memory, word index from addr[9:2], combinational read
    assign loadData = mem[memReq.addr[9:2]];

    // Stores land at the end of the request cycle
    always @(posedge clk)
    begin
        if (!rst && memReq.write)
        begin
            mem[memReq.addr[9:2]] <= memReq.wdata;
        end
    end

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Initial memory contents, distinct per word
    function automatic logic [31:0] fillWord(input logic [7:0] idx);
        return {8'hc3, idx, ~idx, idx ^ 8'h5a};
    endfunction

    // RV32I result rules, alt is instruction bit 30
    function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'b000: r = alt ? a - b : a + b;
            3'b001: r = a << b[4:0];
            3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: r = (a < b) ? 32'd1 : 32'd0;
            3'b100: r = a ^ b;
            3'b101:
            begin
                if (alt)
                    r = $signed(a) >>> b[4:0];
                else
                    r = a >> b[4:0];
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic refBranch(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Funct3 and immediate of each OPIMM case
    function automatic logic [14:0] immCase(input int i);
        case (i)
            0: return {3'b000, 12'h7ff};
            1: return {3'b010, 12'h800};
            2: return {3'b011, 12'hfff};
            3: return {3'b100, 12'h0f0};
            4: return {3'b110, 12'h555};
            5: return {3'b111, 12'hf0f};
            6: return {3'b001, 12'h005};
            7: return {3'b101, 12'h00d};
            default: return {3'b101, 12'h407};
        endcase
    endfunction

    function automatic wbT wbOf(input logic v, input logic [4:0] rd, input logic [31:0] d);
        wbT w;
        w.valid = v;
        w.rd = rd;
        w.data = d;
        return w;
    endfunction

    function automatic memReqT reqOf(input logic rd, input logic wr, input logic [31:0] addr,
                                     input logic [31:0] wdata);
        memReqT q;
        q.read = rd;
        q.write = wr;
        q.addr = addr;
        q.wdata = wdata;
        return q;
    endfunction

    function automatic branchT brOf(input logic taken, input logic [31:0] target);
        branchT b;
        b.taken = taken;
        b.target = target;
        return b;
    endfunction

    // One edge, then settle past it
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    // memReq one cycle after issue, registered outputs two cycles after
    task automatic runInstr(input logic [31:0] word);
        instr = word;
        instrPc = pc;
        nextCycle();
        seenReq = memReq;
        instr = NOP_INSTR;
        instrPc = pc + 32'd4;
        nextCycle();
        seenWb = wb;
        seenBr = branch;
        seenIll = illegal;
    endtask

    task automatic expectAll(input string tag, input logic [31:0] word, input memReqT eReq,
                             input wbT eWb, input branchT eBr, input logic eIll);
        runInstr(word);
        checkMem(tag, eReq, seenReq);
        checkWb(tag, eWb, seenWb);
        checkBranch(tag, eBr, seenBr);
        checkFlag(tag, eIll, seenIll);
        if (eWb.valid && eWb.rd != 5'd0)
            refRegs[eWb.rd] = eWb.data;
        pc = pc + 32'd4;
    endtask

    task automatic expectWrite(input string tag, input logic [31:0] word,
                               input logic [4:0] rd, input logic [31:0] data);
        expectAll(tag, word, reqOf(0, 0, 0, 0), wbOf(1, rd, data), brOf(0, 0), 1'b0);
    endtask

    // LUI takes the rounded upper part so the signed ADDI lands exactly
    task automatic loadReg(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = {{20{value[11]}}, value[11:0]};
        hi = value - lo;
        expectWrite("lui", encU(hi[31:12], rd, LUI), rd, hi);
        expectWrite("addi", encI(value[11:0], rd, 3'b000, rd, OPIMM), rd, value);
    endtask

    // Still at reset values, no edge since release
    task automatic testReset();
        checkWb("reset", wbOf(0, 0, 0), wb);
        checkBranch("reset", brOf(0, 0), branch);
        checkMem("reset", reqOf(0, 0, 0, 0), memReq);
        checkFlag("reset", 1'b0, illegal);
        expectWrite("reset x31", encI(12'h000, 31, 3'b000, 31, OPIMM), 31, 32'h0);
    endtask

    task automatic testImmAlu();
        logic [14:0] c;
        logic [31:0] b;
        logic        alt;
        loadReg(1, 32'h1234_5678);
        loadReg(2, 32'h8765_4321);
        for (int src = 1; src <= 2; src++)
        begin
            for (int i = 0; i < 9; i++)
            begin
                c = immCase(i);
                b = {{20{c[11]}}, c[11:0]};
                alt = (c[14:12] == 3'b101) && c[10];
                expectWrite("opimm", encI(c[11:0], 5'(src), c[14:12], 5'(3 + i), OPIMM),
                            5'(3 + i), refAlu(c[14:12], alt, refRegs[src], b));
            end
        end
        // Result goes out on wb for x0 but must not stick
        expectWrite("x0 write", encI(12'h055, 1, 3'b000, 0, OPIMM), 0, refRegs[1] + 32'h55);
        expectWrite("x0 read", encI(12'h000, 0, 3'b000, 12, OPIMM), 12, 32'h0);
        expectWrite("auipc", encU(20'h12345, 13, AUIPC), 13, pc + 32'h1234_5000);
    endtask

    // Sources and destinations in x8..x15 so results feed later operands
    // One instruction per cycle, wb of n shows after the edge that registers n+1
    task automatic testRandomR();
        logic [31:0] r32;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        alt;
        logic [31:0] words [40];
        wbT          expWb [40];
        for (int r = 8; r < 16; r++)
        begin
            r32 = $random(seed);
            loadReg(5'(r), r32);
        end
        // Model in program order, each result sees the one just before it
        for (int n = 0; n < 40; n++)
        begin
            r32 = $random(seed);
            rs1 = {2'b01, r32[2:0]};
            rs2 = {2'b01, r32[5:3]};
            rd = {2'b01, r32[8:6]};
            f3 = r32[11:9];
            alt = (f3 == 3'b000 || f3 == 3'b101) ? r32[12] : 1'b0;
            words[n] = encR({1'b0, alt, 5'b0}, rs2, rs1, f3, rd);
            expWb[n] = wbOf(1, rd, refAlu(f3, alt, refRegs[rs1], refRegs[rs2]));
            refRegs[rd] = expWb[n].data;
        end
        for (int n = 0; n <= 40; n++)
        begin
            if (n < 40)
                instr = words[n];
            else
                instr = NOP_INSTR;
            instrPc = pc;
            nextCycle();
            if (n > 0)
                checkWb("op", expWb[n - 1], wb);
            pc = pc + 32'd4;
        end
    endtask

    task automatic testMemory();
        logic [31:0] word;
        word = $random(seed);
        loadReg(20, 32'h0000_0040);
        loadReg(21, word);
        expectAll("sw", encS(12'h008, 21, 20, 3'b010), reqOf(0, 1, 32'h48, word),
                  wbOf(0, 0, 0), brOf(0, 0), 1'b0);
        expectAll("lw", encI(12'h008, 20, 3'b010, 22, LOAD), reqOf(1, 0, 32'h48, 0),
                  wbOf(1, 22, word), brOf(0, 0), 1'b0);
        // Negative offset below the base
        expectAll("sw neg", encS(12'hffc, 21, 20, 3'b010), reqOf(0, 1, 32'h3c, word),
                  wbOf(0, 0, 0), brOf(0, 0), 1'b0);
        expectAll("lw neg", encI(12'hffc, 20, 3'b010, 23, LOAD), reqOf(1, 0, 32'h3c, 0),
                  wbOf(1, 23, word), brOf(0, 0), 1'b0);
        expectAll("lw fill", encI(12'h010, 20, 3'b010, 23, LOAD), reqOf(1, 0, 32'h50, 0),
                  wbOf(1, 23, fillWord(8'h14)), brOf(0, 0), 1'b0);
    endtask

    // Pairs (5,5), (5,-3), (-3,5) give taken and not taken for every condition
    task automatic testBranches();
        logic [2:0]  f3;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [12:0] off;
        logic        taken;
        loadReg(24, 32'd5);
        loadReg(25, 32'hffff_fffd);
        loadReg(26, 32'd5);
        for (int i = 0; i < 6; i++)
        begin
            f3 = (i < 2) ? 3'(i) : 3'(i + 2);
            for (int p = 0; p < 3; p++)
            begin
                ra = (p == 2) ? 5'd25 : 5'd24;
                rb = (p == 0) ? 5'd26 : ((p == 1) ? 5'd25 : 5'd24);
                off = (p == 1) ? 13'h1fe0 : 13'h0040;
                taken = refBranch(f3, refRegs[ra], refRegs[rb]);
                expectAll("branch", encB(off, rb, ra, f3), reqOf(0, 0, 0, 0), wbOf(0, 0, 0),
                          brOf(taken, pc + {{19{off[12]}}, off}), 1'b0);
            end
        end
        expectAll("jal fwd", encJ(21'h000100, 1), reqOf(0, 0, 0, 0), wbOf(1, 1, pc + 32'd4),
                  brOf(1, pc + 32'h100), 1'b0);
        expectAll("jal back", encJ(21'h1fff00, 3), reqOf(0, 0, 0, 0), wbOf(1, 3, pc + 32'd4),
                  brOf(1, pc - 32'h100), 1'b0);
        // 5 + 16 is odd, low bit dropped
        expectAll("jalr", encI(12'h010, 24, 3'b000, 5, JALR), reqOf(0, 0, 0, 0),
                  wbOf(1, 5, pc + 32'd4), brOf(1, 32'd20), 1'b0);
    endtask

    task automatic testIllegal();
        expectAll("bad opcode", 32'h0000_007f, reqOf(0, 0, 0, 0), wbOf(0, 0, 0), brOf(0, 0),
                  1'b1);
        // Flag drops once the NOP behind it reaches the outputs
        nextCycle();
        checkFlag("illegal drop", 1'b0, illegal);
        expectAll("bad funct7", encR(7'b0000001, 2, 1, 3'b000, 7), reqOf(0, 0, 0, 0),
                  wbOf(0, 0, 0), brOf(0, 0), 1'b1);
        expectWrite("x7 kept", encI(12'h000, 7, 3'b000, 12, OPIMM), 12, refRegs[7]);
    endtask

    initial
    begin
        seed = 32'h862f2d15;
        pc = 32'h0000_1000;
        rst = 1'b1;
        instr = NOP_INSTR;
        instrPc = 32'h0;
        for (int i = 0; i < 256; i++)
            mem[i] = fillWord(8'(i));
        for (int i = 0; i < 32; i++)
            refRegs[i] = 32'h0;
        for (int i = 0; i < 8; i++)
            @(posedge clk);
        #1;
        rst = 1'b0;
        testReset();
        testImmAlu();
        testRandomR();
        testMemory();
        testBranches();
        testIllegal();
        finished = 1'b1;
        $display("Error counts: wb %0d, branch %0d, mem %0d, illegal %0d",
                 wbErrs, brErrs, memErrs, flagErrs);
        if (wbErrs + brErrs + memErrs + flagErrs == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // Watchdog over the whole run
    initial
    begin
        int cycles;
        cycles = 0;
        while (!finished && cycles < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (!finished)
        begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

endmodule

/* design/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
    input  rvPkg::decodedT         dec,
    input  logic [rvPkg::XLEN-1:0] rsData1,
    input  logic [rvPkg::XLEN-1:0] rsData2,
    output logic [rvPkg::XLEN-1:0] aluResult
);
    import rvPkg::*;

    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [4:0]      shamt;

    // Operand A: PC for AUIPC and JAL
    assign opA = dec.ctrl.aluSrcPc ? dec.pc : rsData1;

    // Operand B: immediate for everything but OP and branches
    assign opB = dec.ctrl.aluSrcImm ? dec.imm : rsData2;

    // Shift amount from low bits of B
    assign shamt = opB[4:0];

    always_comb
    begin
        case (dec.ctrl.aluOp)
            AND:
                aluResult = opA & opB;
            OR:
                aluResult = opA | opB;
            XOR:
                aluResult = opA ^ opB;
            ADD:
                aluResult = opA + opB;
            SUB:
                aluResult = opA - opB;
            SLL:
                aluResult = opA << shamt;
            SRL:
                aluResult = opA >> shamt;
            SRA:
                aluResult = $unsigned($signed(opA) >>> shamt);
            SLT:
                aluResult = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            SLTU:
                aluResult = {{(XLEN-1){1'b0}}, opA < opB};
            PASSB:
                aluResult = opB;    // LUI
            default:
                aluResult = '0;
        endcase
    end

endmodule

/* design/coreSlice.sv */
`timescale 1ns/1ps

module coreSlice (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [31:0]            instr,
    input  logic [31:0]            instrPc,
    input  logic [rvPkg::XLEN-1:0] loadData,
    output rvPkg::memReqT          memReq,
    output rvPkg::wbT              wb,
    output rvPkg::branchT          branch,
    output logic                   illegal
);
    import rvPkg::*;

    decodedT         dec;
    logic [XLEN-1:0] rsData1;
    logic [XLEN-1:0] rsData2;
    logic [XLEN-1:0] aluResult;

    // Stage 1: instruction register and decode
    instrDecoder decoder0 (
        .clk     (clk),
        .rst     (rst),
        .instr   (instr),
        .instrPc (instrPc),
        .dec     (dec)
    );

    // Write port fed back from the registered write-back
    // so instruction k+1 sees the result of k
    regFile regFile0 (
        .clk     (clk),
        .rst     (rst),
        .rs1     (dec.rs1),
        .rs2     (dec.rs2),
        .rsData1 (rsData1),
        .rsData2 (rsData2),
        .wbIn    (wb)
    );

    aluUnit alu0 (
        .dec       (dec),
        .rsData1   (rsData1),
        .rsData2   (rsData2),
        .aluResult (aluResult)
    );

    // Stage 2: result select, branch resolve, output registers
    writebackStage writeback0 (
        .clk       (clk),
        .rst       (rst),
        .dec       (dec),
        .rsData1   (rsData1),
        .rsData2   (rsData2),
        .aluResult (aluResult),
        .loadData  (loadData),
        .wb        (wb),
        .branch    (branch),
        .illegal   (illegal)
    );

    // Data memory request, one cycle after the instruction
    // Address is the ALU sum rs1 + imm, store data from rs2
    assign memReq = '{
        read:  dec.ctrl.memRead,
        write: dec.ctrl.memWrite,
        addr:  aluResult,
        wdata: rsData2
    };

endmodule

/* design/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
    input  logic           clk,
    input  logic           rst,
    input  logic [31:0]    instr,
    input  logic [31:0]    instrPc,
    output rvPkg::decodedT dec
);
    import rvPkg::*;

    logic [31:0] instrQ;
    logic [31:0] pcQ;
    opcodeE      opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    ctrlT        ctrl;
    logic [31:0] imm;
    logic        illegal;

    // Shared funct3 to ALU op mapping for OP and OPIMM
    // alt is instruction bit 30, selects SUB or SRA
    function automatic aluOpE mapAluOp(input logic [2:0] f3, input logic alt, input logic isReg);
        aluOpE op;
        case (f3)
            3'b000:  op = (alt && isReg) ? SUB : ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = alt ? SRA : SRL;
            3'b110:  op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    // Instruction register, NOP after reset
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            instrQ <= NOP_INSTR;
            pcQ <= '0;
        end
        else
        begin
            instrQ <= instr;
            pcQ <= instrPc;
        end
    end

    // Fixed instruction fields
    assign opcode = opcodeE'(instrQ[6:0]);
    assign funct3 = instrQ[14:12];
    assign funct7 = instrQ[31:25];

    always_comb
    begin
        ctrl = '0;
        imm = '0;
        illegal = 1'b0;
        case (opcode)
            LUI:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = PASSB;
                imm = {instrQ[31:12], 12'b0};
            end
            AUIPC:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluSrcPc = 1'b1;
                ctrl.aluOp = ADD;
                imm = {instrQ[31:12], 12'b0};
            end
            JAL:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.isJal = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluSrcPc = 1'b1;
                ctrl.aluOp = ADD;
                imm = {{11{instrQ[31]}}, instrQ[31], instrQ[19:12], instrQ[20],
                       instrQ[30:21], 1'b0};
            end
            JALR:
            begin
                // Target comes from the ALU sum rs1 + imm
                ctrl.regWrite = 1'b1;
                ctrl.isJalr = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = ADD;
                imm = {{20{instrQ[31]}}, instrQ[31:20]};
            end
            BRANCH:
            begin
                ctrl.isBranch = 1'b1;
                ctrl.aluOp = SUB;
                imm = {{19{instrQ[31]}}, instrQ[31], instrQ[7], instrQ[30:25],
                       instrQ[11:8], 1'b0};
            end
            LOAD:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = ADD;
                imm = {{20{instrQ[31]}}, instrQ[31:20]};
            end
            STORE:
            begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = ADD;
                imm = {{20{instrQ[31]}}, instrQ[31:25], instrQ[11:7]};
            end
            OPIMM:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = mapAluOp(funct3, instrQ[30], 1'b0);
                imm = {{20{instrQ[31]}}, instrQ[31:20]};
            end
            OP:
            begin
                // Only 0000000, or 0100000 with ADD/SR slots, are defined
                if (funct7 == 7'b0000000 ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)))
                begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp = mapAluOp(funct3, instrQ[30], 1'b1);
                end
                else
                begin
                    illegal = 1'b1;
                end
            end
            default:
            begin
                illegal = 1'b1;
            end
        endcase
    end

    assign dec = '{
        ctrl:    ctrl,
        rd:      instrQ[11:7],
        rs1:     instrQ[19:15],
        rs2:     instrQ[24:20],
        funct3:  funct3,
        imm:     imm,
        pc:      pcQ,
        illegal: illegal
    };

endmodule

/* design/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [4:0]             rs1,
    input  logic [4:0]             rs2,
    output logic [rvPkg::XLEN-1:0] rsData1,
    output logic [rvPkg::XLEN-1:0] rsData2,
    input  rvPkg::wbT              wbIn
);
    import rvPkg::*;

    logic [XLEN-1:0] regs [REG_COUNT];

    // Whole file cleared on reset
    // Writes to x0 are dropped
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wbIn.valid && wbIn.rd != 5'd0)
        begin
            regs[wbIn.rd] <= wbIn.data;
        end
    end

    // Combinational reads
    // x0 forced to zero regardless of array contents
    // Result of the instruction just ahead comes straight from wbIn,
    // the array only takes it at the following edge
    assign rsData1 = (rs1 == 5'd0) ? '0 :
                     (wbIn.valid && wbIn.rd == rs1) ? wbIn.data : regs[rs1];
    assign rsData2 = (rs2 == 5'd0) ? '0 :
                     (wbIn.valid && wbIn.rd == rs2) ? wbIn.data : regs[rs2];

endmodule

/* design/rvPkg.sv */
package rvPkg;

    // Architectural sizes fixed by RV32I
    localparam int XLEN = 32;
    localparam int REG_COUNT = 32;

    // ADDI x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

    // Branch conditions carried in funct3
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Major opcodes, low two bits always 11
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OPIMM  = 7'b0010011,
        OP     = 7'b0110011
    } opcodeE;

    // ALU operations, AND at zero so a cleared control word is still a member
    typedef enum logic [3:0] {
        AND   = 4'd0,
        OR    = 4'd1,
        XOR   = 4'd2,
        ADD   = 4'd3,
        SUB   = 4'd4,
        SLL   = 4'd5,
        SRL   = 4'd6,
        SRA   = 4'd7,
        SLT   = 4'd8,
        SLTU  = 4'd9,
        PASSB = 4'd10
    } aluOpE;

    // Decoded control word
    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  aluSrcImm;   // B operand from immediate
        logic  aluSrcPc;    // A operand from PC
        logic  isBranch;
        logic  isJal;
        logic  isJalr;
        aluOpE aluOp;
    } ctrlT;

    // Everything downstream needs from decode
    typedef struct packed {
        ctrlT        ctrl;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic [31:0] imm;
        logic [31:0] pc;
        logic        illegal;
    } decodedT;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } wbT;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } branchT;

    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } memReqT;

endpackage

/* design/writebackStage.sv */
`timescale 1ns/1ps

module writebackStage (
    input  logic                   clk,
    input  logic                   rst,
    input  rvPkg::decodedT         dec,
    input  logic [rvPkg::XLEN-1:0] rsData1,
    input  logic [rvPkg::XLEN-1:0] rsData2,
    input  logic [rvPkg::XLEN-1:0] aluResult,
    input  logic [rvPkg::XLEN-1:0] loadData,
    output rvPkg::wbT              wb,
    output rvPkg::branchT          branch,
    output logic                   illegal
);
    import rvPkg::*;

    logic            isEq;
    logic            isLt;
    logic            isLtu;
    logic            condMet;
    logic            takenNext;
    logic [XLEN-1:0] targetNext;
    logic [XLEN-1:0] linkData;
    logic [XLEN-1:0] wbDataNext;
    logic            wbValidQ;
    logic [4:0]      wbRdQ;
    logic [XLEN-1:0] wbDataQ;
    logic            takenQ;
    logic [XLEN-1:0] targetQ;
    logic            illegalQ;

    // Comparisons for the six branch conditions
    assign isEq = (rsData1 == rsData2);
    assign isLt = ($signed(rsData1) < $signed(rsData2));
    assign isLtu = (rsData1 < rsData2);

    always_comb
    begin
        case (dec.funct3)
            F3_BEQ:  condMet = isEq;
            F3_BNE:  condMet = !isEq;
            F3_BLT:  condMet = isLt;
            F3_BGE:  condMet = !isLt;
            F3_BLTU: condMet = isLtu;
            F3_BGEU: condMet = !isLtu;
            default: condMet = 1'b0;    // 010 and 011 never taken
        endcase
    end

    assign takenNext = (dec.ctrl.isBranch && condMet) || dec.ctrl.isJal || dec.ctrl.isJalr;

    // JALR clears bit 0 of rs1 + imm, others are PC relative
    assign targetNext = dec.ctrl.isJalr ? {aluResult[XLEN-1:1], 1'b0} : dec.pc + dec.imm;

    // Return address for jumps
    assign linkData = dec.pc + 32'd4;

    assign wbDataNext = dec.ctrl.memRead ? loadData :
                        (dec.ctrl.isJal || dec.ctrl.isJalr) ? linkData : aluResult;

    // Strobes, cleared on reset
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wbValidQ <= 1'b0;
            takenQ <= 1'b0;
            illegalQ <= 1'b0;
        end
        else
        begin
            wbValidQ <= dec.ctrl.regWrite;
            takenQ <= takenNext;
            illegalQ <= dec.illegal;
        end
    end

    // Write-back payload and branch target
    always_ff @(posedge clk)
    begin
        wbRdQ <= dec.rd;
        wbDataQ <= wbDataNext;
        targetQ <= targetNext;
    end

    assign wb = '{valid: wbValidQ, rd: wbRdQ, data: wbDataQ};
    assign branch = '{taken: takenQ, target: targetQ};
    assign illegal = illegalQ;

endmodule

/* sources.f */
+incdir+bench
design/rvPkg.sv
design/instrDecoder.sv
design/regFile.sv
design/aluUnit.sv
design/writebackStage.sv
design/coreSlice.sv
bench/coreSliceTb.sv
